// ==== build.f ====
+incdir+src
src/robTypesPkg.sv
src/robRegsPkg.sv
src/robCtrlIf.sv
src/robCtrlRegs.sv
src/reorderBuffer.sv
src/robTop.sv
test/tbRobTop.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the reorder buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing -Wno-fatal --top-module tbRobTop -f build.f -o simRob \
    > build.log 2>&1 \
    && ./obj_dir/simRob > "$LOG" 2>&1 \
    || { cat build.log "$LOG" 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat "$LOG"
grep -q "Done: errors found" "$LOG" && { echo "Simulation FAILED"; exit 1; }
grep -q "Done: no errors" "$LOG" || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

// ==== src/reorderBuffer.sv ====
`timescale 1ns/1ps
`include "rob_config.svh"

module reorderBuffer import robTypesPkg::*; (
    input  logic                             clk,
    input  logic                             rst,

    input  logic [`ROB_WIDTH-1:0]            dispValid,
    input  RegNm [`ROB_WIDTH-1:0]            dispDst,
    output logic                             dispReady,
    output SqN                               tailSqN,

    input  logic [`ROB_WB_PORTS-1:0]         wbValid,
    input  SqN [`ROB_WB_PORTS-1:0]           wbSqN,
    input  CompFlags [`ROB_WB_PORTS-1:0]     wbFlags,

    output logic [`ROB_WIDTH-1:0]            comValid,
    output SqN [`ROB_WIDTH-1:0]              comSqN,
    output RegNm [`ROB_WIDTH-1:0]            comDst,

    output logic                             flushValid,
    output SqN                               flushSqN,
    output FlushCause                        flushCause,

    robCtrlIf.rob                            ctrl
);

    localparam int IDX_BITS = $clog2(`ROB_DEPTH);
    localparam int CNT_BITS = $clog2(`ROB_WIDTH+1);

    RobEntry entries [`ROB_DEPTH];
    SqN      head;
    SqN      tail;
    SqN      occupancy;

    SqN [`ROB_WIDTH-1:0]  laneSq;
    logic [`ROB_WIDTH-1:0] takeLane;
    logic [CNT_BITS-1:0]  takeCnt;
    logic                 doFlush;
    SqN                   flushAt;
    FlushCause            cause;

    SqN [`ROB_WIDTH-1:0]  dispSq;
    logic [CNT_BITS-1:0]  dispCnt;
    logic [`ROB_WB_PORTS-1:0] wbHit;

    assign occupancy = tail - head;
    assign dispReady = (SqN'(`ROB_DEPTH) - occupancy) >= SqN'(`ROB_WIDTH);
    assign tailSqN   = tail;

    assign ctrl.occupancy  = occupancy;
    assign ctrl.flushPulse = flushValid;

    always_comb begin
        ctrl.commitPulse = '0;
        for (int i = 0; i < `ROB_WIDTH; i++) begin
            ctrl.commitPulse = ctrl.commitPulse + CNT_BITS'(comValid[i]);
        end
    end

    // Oldest entries first, stop at the first one not ready or flagged
    always_comb begin
        logic    stop;
        RobEntry cur;
        stop     = ctrl.holdCommit;
        takeLane = '0;
        takeCnt  = '0;
        doFlush  = 1'b0;
        flushAt  = head;
        cause    = causeExcept;
        for (int i = 0; i < `ROB_WIDTH; i++) begin
            laneSq[i] = head + SqN'(i);
            cur = entries[laneSq[i][IDX_BITS-1:0]];
            if (ctrl.singleWidth && i > 0) begin
                stop = 1'b1;
            end
            if (!stop && cur.valid && cur.executed) begin
                if (cur.flags != flagsExcept) begin
                    takeLane[i] = 1'b1;
                    takeCnt     = takeCnt + 1'b1;
                end
                if (cur.flags != flagsNone) begin
                    doFlush = 1'b1;
                    flushAt = laneSq[i];
                    cause   = (cur.flags == flagsMispred) ? causeMispred : causeExcept;
                    stop    = 1'b1;
                end
            end else begin
                stop = 1'b1;
            end
        end
    end

    // Lanes pack in order from the tail
    always_comb begin
        dispCnt = '0;
        for (int k = 0; k < `ROB_WIDTH; k++) begin
            dispSq[k] = tail + SqN'(dispCnt);
            if (dispValid[k]) begin
                dispCnt = dispCnt + 1'b1;
            end
        end
    end

    // Entries carry no wrap bit, so check the window as well
    always_comb begin
        for (int p = 0; p < `ROB_WB_PORTS; p++) begin
            wbHit[p] = wbValid[p] && entries[wbSqN[p][IDX_BITS-1:0]].valid
                && !sqnBefore(wbSqN[p], head) && sqnBefore(wbSqN[p], tail);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head       <= '0;
            tail       <= '0;
            comValid   <= '0;
            flushValid <= 1'b0;
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                entries[i].valid    <= 1'b0;
                entries[i].executed <= 1'b0;
            end
        end else begin
            comValid   <= takeLane;
            flushValid <= doFlush;

            for (int p = 0; p < `ROB_WB_PORTS; p++) begin
                if (wbHit[p]) begin
                    entries[wbSqN[p][IDX_BITS-1:0]].executed <= 1'b1;
                    entries[wbSqN[p][IDX_BITS-1:0]].flags    <= wbFlags[p];
                end
            end

            for (int i = 0; i < `ROB_WIDTH; i++) begin
                if (takeLane[i]) begin
                    entries[laneSq[i][IDX_BITS-1:0]].valid    <= 1'b0;
                    entries[laneSq[i][IDX_BITS-1:0]].executed <= 1'b0;
                end
            end

            head <= head + SqN'(takeCnt);

            if (doFlush) begin
                // Everything older commits this cycle, so the whole buffer empties
                for (int i = 0; i < `ROB_DEPTH; i++) begin
                    entries[i].valid    <= 1'b0;
                    entries[i].executed <= 1'b0;
                end
                tail <= head + SqN'(takeCnt);
            end else if (dispReady) begin
                for (int k = 0; k < `ROB_WIDTH; k++) begin
                    if (dispValid[k]) begin
                        entries[dispSq[k][IDX_BITS-1:0]] <= '{valid: 1'b1, executed: 1'b0,
                            dst: dispDst[k], flags: flagsNone};
                    end
                end
                tail <= tail + SqN'(dispCnt);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `ROB_WIDTH; i++) begin
            comSqN[i] <= laneSq[i];
            comDst[i] <= entries[laneSq[i][IDX_BITS-1:0]].dst;
        end
        flushSqN   <= flushAt;
        flushCause <= cause;
    end

endmodule

// ==== src/robCtrlIf.sv ====
`timescale 1ns/1ps
`include "rob_config.svh"

interface robCtrlIf import robRegsPkg::*; ();

    CtrlWord word;
    logic    holdCommit;
    logic    singleWidth;

    logic [`ROB_SQN_BITS-1:0]         occupancy;
    logic [$clog2(`ROB_WIDTH+1)-1:0] commitPulse;
    logic                             flushPulse;

    // Control bits as seen by the buffer
    assign holdCommit  = word.holdCommit;
    assign singleWidth = word.singleWidth;

    modport regs (output word, input occupancy, commitPulse, flushPulse);

    modport rob (input holdCommit, singleWidth, output occupancy, commitPulse, flushPulse);

endinterface

// ==== src/robCtrlRegs.sv ====
`timescale 1ns/1ps
`include "rob_config.svh"

module robCtrlRegs import robRegsPkg::*; (
    input  logic                          clk,
    input  logic                          rst,

    input  logic [`AXI_ADDR_BITS-1:0]     awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [`AXI_DATA_BITS-1:0]     wdata,
    input  logic [`AXI_DATA_BITS/8-1:0]   wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output AxiResp                        bresp,
    output logic                          bvalid,
    input  logic                          bready,

    input  logic [`AXI_ADDR_BITS-1:0]     araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [`AXI_DATA_BITS-1:0]     rdata,
    output AxiResp                        rresp,
    output logic                          rvalid,
    input  logic                          rready,

    robCtrlIf.regs                        ctrl
);

    localparam int DATA_BITS = `AXI_DATA_BITS;

    CtrlWord              ctrlReg;
    logic [DATA_BITS-1:0] commits;
    logic [DATA_BITS-1:0] flushes;

    assign ctrl.word = ctrlReg;

    // Write channel, address and data are taken together
    always_ff @(posedge clk) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            ctrlReg <= '0;
            commits <= '0;
            flushes <= '0;
        end else begin
            commits <= commits + DATA_BITS'(ctrl.commitPulse);
            flushes <= flushes + DATA_BITS'(ctrl.flushPulse);

            if (awready) begin
                awready <= 1'b0;
                wready  <= 1'b0;
                bvalid  <= 1'b1;
                bresp   <= respOkay;
                case (awaddr)
                    regCtrl: begin
                        if (wstrb[0]) begin
                            ctrlReg <= CtrlWord'(wdata[$bits(CtrlWord)-1:0]);
                        end
                    end
                    regCommits: commits <= '0;
                    regFlushes: flushes <= '0;
                    // Status is read-only
                    default: bresp <= respSlvErr;
                endcase
            end else if (awvalid && wvalid && !bvalid) begin
                awready <= 1'b1;
                wready  <= 1'b1;
            end

            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // Read channel
    always_ff @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            if (arready) begin
                arready <= 1'b0;
                rvalid  <= 1'b1;
                rresp   <= respOkay;
                case (araddr)
                    regCtrl:    rdata <= DATA_BITS'(ctrlReg);
                    regStatus:  rdata <= DATA_BITS'(ctrl.occupancy);
                    regCommits: rdata <= commits;
                    regFlushes: rdata <= flushes;
                    default: begin
                        rdata <= '0;
                        rresp <= respSlvErr;
                    end
                endcase
            end else if (arvalid && !rvalid) begin
                arready <= 1'b1;
            end

            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

endmodule

// ==== src/robRegsPkg.sv ====
`include "rob_config.svh"

package robRegsPkg;

    typedef enum logic [`AXI_ADDR_BITS-1:0] {
        regCtrl    = 'h0,
        regStatus  = 'h4,
        regCommits = 'h8,
        regFlushes = 'hC
    } RegAddr;

    // Bit 1 holds commit, bit 0 limits commit to one lane
    typedef struct packed {
        logic holdCommit;
        logic singleWidth;
    } CtrlWord;

    typedef enum logic [1:0] {
        respOkay   = 2'b00,
        respSlvErr = 2'b10
    } AxiResp;

endpackage

// ==== src/robTop.sv ====
`timescale 1ns/1ps
`include "rob_config.svh"

module robTop import robTypesPkg::*; (
    input  logic                           clk,
    input  logic                           rst,

    input  logic [`ROB_WIDTH-1:0]          dispValid,
    input  RegNm [`ROB_WIDTH-1:0]          dispDst,
    output logic                           dispReady,
    output SqN                             tailSqN,

    input  logic [`ROB_WB_PORTS-1:0]       wbValid,
    input  SqN [`ROB_WB_PORTS-1:0]         wbSqN,
    input  CompFlags [`ROB_WB_PORTS-1:0]   wbFlags,

    output logic [`ROB_WIDTH-1:0]          comValid,
    output SqN [`ROB_WIDTH-1:0]            comSqN,
    output RegNm [`ROB_WIDTH-1:0]          comDst,

    output logic                           flushValid,
    output SqN                             flushSqN,
    output FlushCause                      flushCause,

    input  logic [`AXI_ADDR_BITS-1:0]      awaddr,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [`AXI_DATA_BITS-1:0]      wdata,
    input  logic [`AXI_DATA_BITS/8-1:0]    wstrb,
    input  logic                           wvalid,
    output logic                           wready,
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  logic                           bready,
    input  logic [`AXI_ADDR_BITS-1:0]      araddr,
    input  logic                           arvalid,
    output logic                           arready,
    output logic [`AXI_DATA_BITS-1:0]      rdata,
    output logic [1:0]                     rresp,
    output logic                           rvalid,
    input  logic                           rready
);

    robCtrlIf ctrlBus ();

    robCtrlRegs i_robCtrlRegs (
        .clk, .rst,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .ctrl(ctrlBus.regs)
    );

    reorderBuffer i_reorderBuffer (
        .clk, .rst,
        .dispValid, .dispDst, .dispReady, .tailSqN,
        .wbValid, .wbSqN, .wbFlags,
        .comValid, .comSqN, .comDst,
        .flushValid, .flushSqN, .flushCause,
        .ctrl(ctrlBus.rob)
    );

endmodule

// ==== src/robTypesPkg.sv ====
`include "rob_config.svh"

package robTypesPkg;

    // Sequence number with wrap bit, ages compare by sign of the difference
    typedef logic [`ROB_SQN_BITS-1:0] SqN;

    typedef logic [`ROB_NAME_BITS-1:0] RegNm;

    typedef enum logic [1:0] {
        flagsNone    = 2'd0,
        flagsExcept  = 2'd1,
        flagsMispred = 2'd2
    } CompFlags;

    typedef struct packed {
        logic     valid;
        logic     executed;
        RegNm     dst;
        CompFlags flags;
    } RobEntry;

    typedef enum logic {
        causeExcept  = 1'b0,
        causeMispred = 1'b1
    } FlushCause;

    // True when a is older than b
    function automatic logic sqnBefore(SqN a, SqN b);
        SqN diff;
        diff = a - b;
        return diff[`ROB_SQN_BITS-1];
    endfunction

endpackage

// ==== src/rob_config.svh ====
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// Buffer geometry
`define ROB_DEPTH 16
`define ROB_WIDTH 2
`define ROB_WB_PORTS 2

// Depth index plus one wrap bit
`define ROB_SQN_BITS 5
`define ROB_NAME_BITS 5

// Register port
`define AXI_ADDR_BITS 4
`define AXI_DATA_BITS 32

`endif

// ==== test/rob_tests.txt ====
# Command then hex fields: disp mask d0 d1 / wb mask sq0 f0 sq1 f1 / axw|axr addr data resp
# commit count firstSq maxPerCycle / flush sq cause / quiet cycles / ready level / counts
test inorder
disp 3 0a 0b
disp 3 0c 0d
wb 3 3 0 2 0
wb 3 1 0 0 0
commit 4 0 2
test width
axw 0 1 0
disp 3 01 02
disp 3 03 04
wb 3 4 0 5 0
wb 3 6 0 7 0
commit 4 4 1
test hold
axw 0 2 0
disp 3 05 06
wb 3 8 0 9 0
quiet 6
axw 0 0 0
commit 2 8 2
test mispred
disp 3 07 08
disp 3 09 0a
wb 3 b 2 a 0
wb 3 d 0 c 0
commit 2 a 2
flush b 1
quiet 4
test except
disp 3 0b 0c
disp 1 0d 00
wb 3 c 0 d 1
wb 1 e 0 0 0
commit 1 c 2
flush d 0
quiet 4
test full
axw 0 2 0
disp 3 10 11
disp 3 12 13
disp 3 14 15
disp 3 16 17
disp 3 18 19
disp 3 1a 1b
disp 3 1c 1d
disp 3 1e 1f
disp 3 01 02
ready 0
axr 4 10 0
test regs
counts
axw 8 0 0
axw c 0 0
counts
axr 0 2 0
axr 1 0 2
axw 4 0 2

// ==== test/tbRobTop.sv ====
`timescale 1ns/1ps
`include "rob_config.svh"

module tbRobTop
    import robTypesPkg::*, robRegsPkg::*;
();

    localparam int WAIT_LIMIT = 64;

    logic                             clk;
    logic                             rst;
    logic [`ROB_WIDTH-1:0]            dispValid;
    RegNm [`ROB_WIDTH-1:0]            dispDst;
    logic                             dispReady;
    SqN                               tailSqN;
    logic [`ROB_WB_PORTS-1:0]         wbValid;
    SqN [`ROB_WB_PORTS-1:0]           wbSqN;
    CompFlags [`ROB_WB_PORTS-1:0]     wbFlags;
    logic [`ROB_WIDTH-1:0]            comValid;
    SqN [`ROB_WIDTH-1:0]              comSqN;
    RegNm [`ROB_WIDTH-1:0]            comDst;
    logic                             flushValid;
    SqN                               flushSqN;
    FlushCause                        flushCause;
    logic [`AXI_ADDR_BITS-1:0]        awaddr;
    logic                             awvalid;
    logic                             awready;
    logic [`AXI_DATA_BITS-1:0]        wdata;
    logic [`AXI_DATA_BITS/8-1:0]      wstrb;
    logic                             wvalid;
    logic                             wready;
    logic [1:0]                       bresp;
    logic                             bvalid;
    logic                             bready;
    logic [`AXI_ADDR_BITS-1:0]        araddr;
    logic                             arvalid;
    logic                             arready;
    logic [`AXI_DATA_BITS-1:0]        rdata;
    logic [1:0]                       rresp;
    logic                             rvalid;
    logic                             rready;

    int              valueErrors;
    int              otherErrors;
    logic            hung;
    logic [8*16-1:0] testName;

    // Reference model keeps the names by sequence number
    RegNm modelDst [2**`ROB_SQN_BITS];
    SqN   modelHead;
    SqN   modelTail;
    int   modelCommits;
    int   modelFlushes;
    time  comTime;
    time  flushTime;

    robTop i_robTop (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic checkCommit(SqN expSq, RegNm expDst, SqN gotSq, RegNm gotDst);
        if (gotSq !== expSq || gotDst !== expDst) begin
            $display("FAILED %0s: commit expected sqN %0d dst %0d, actual sqN %0d dst %0d",
                testName, expSq, expDst, gotSq, gotDst);
            valueErrors++;
        end
    endtask

    task automatic checkFlush(SqN expSq, FlushCause expCause, SqN expTail,
                              SqN gotSq, FlushCause gotCause, SqN gotTail);
        if (gotSq !== expSq || gotCause !== expCause || gotTail !== expTail) begin
            $display("FAILED %0s: flush expected sqN %0d %s tail %0d, actual sqN %0d %s tail %0d",
                testName, expSq, expCause.name(), expTail, gotSq, gotCause.name(), gotTail);
            valueErrors++;
        end
    endtask

    task automatic checkReg(logic [`AXI_DATA_BITS-1:0] expData, AxiResp expResp,
                            logic [`AXI_DATA_BITS-1:0] gotData, AxiResp gotResp);
        if (gotData !== expData || gotResp !== expResp) begin
            $display("FAILED %0s: register expected 0x%08h %s, actual 0x%08h %s",
                testName, expData, expResp.name(), gotData, gotResp.name());
            valueErrors++;
        end
    endtask

    task automatic checkReady(logic expReady, logic gotReady);
        if (gotReady !== expReady) begin
            $display("FAILED %0s: dispReady expected %0b, actual %0b",
                testName, expReady, gotReady);
            valueErrors++;
        end
    endtask

    task automatic reportTimeout(string what);
        $display("Timeout in %0s while waiting for %0s", testName, what);
        otherErrors++;
        hung = 1'b1;
    endtask

    task automatic dispatchOps(logic [`ROB_WIDTH-1:0] mask, RegNm d0, RegNm d1);
        SqN   used;
        logic modelReady;
        used       = modelTail - modelHead;
        modelReady = (`ROB_DEPTH - int'(used)) >= `ROB_WIDTH;
        dispValid  = mask;
        dispDst[0] = d0;
        dispDst[1] = d1;
        checkReady(modelReady, dispReady);
        // Accepted lanes take consecutive sequence numbers
        if (modelReady) begin
            for (int k = 0; k < `ROB_WIDTH; k++) begin
                if (mask[k]) begin
                    modelDst[modelTail] = dispDst[k];
                    modelTail++;
                end
            end
        end
        @(negedge clk);
        dispValid = '0;
    endtask

    task automatic writeBack(logic [`ROB_WB_PORTS-1:0] mask, SqN s0, CompFlags f0,
                             SqN s1, CompFlags f1);
        wbValid    = mask;
        wbSqN[0]   = s0;
        wbFlags[0] = f0;
        wbSqN[1]   = s1;
        wbFlags[1] = f1;
        @(negedge clk);
        wbValid = '0;
    endtask

    task automatic expectCommits(int count, SqN firstSq, int maxPerCycle);
        int n;
        int lanes;
        SqN expSq;
        expSq = firstSq;
        modelCommits += count;
        while (count > 0 && !hung) begin
            n = 0;
            while ((comValid == '0 || $time == comTime) && n < WAIT_LIMIT) begin
                @(negedge clk);
                n++;
            end
            if (comValid == '0 || $time == comTime) begin
                reportTimeout("comValid");
            end else begin
                comTime = $time;
                lanes   = 0;
                for (int l = 0; l < `ROB_WIDTH; l++) begin
                    if (comValid[l]) begin
                        if (count == 0) begin
                            $display("%0s: sqN %0d committed beyond the expected ops",
                                testName, comSqN[l]);
                            otherErrors++;
                        end else begin
                            checkCommit(expSq, modelDst[expSq], comSqN[l], comDst[l]);
                            expSq++;
                            modelHead = expSq;
                            count--;
                        end
                        lanes++;
                    end
                end
                if (lanes > maxPerCycle) begin
                    $display("%0s: %0d ops committed in one cycle, more than the limit of %0d",
                        testName, lanes, maxPerCycle);
                    otherErrors++;
                end
            end
        end
    endtask

    task automatic expectFlush(SqN expSq, FlushCause expCause);
        int n;
        n = 0;
        while ((!flushValid || $time == flushTime) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!flushValid || $time == flushTime) begin
            reportTimeout("flushValid");
        end else begin
            flushTime = $time;
            modelFlushes++;
            // A mispredict keeps the branch and an exception drops the flagged op
            if (expCause == causeMispred) begin
                modelTail = expSq + 1'b1;
            end else begin
                modelTail = expSq;
            end
            modelHead = modelTail;
            checkFlush(expSq, expCause, modelTail, flushSqN, flushCause, tailSqN);
            @(negedge clk);
        end
    endtask

    task automatic expectQuiet(int cycles);
        repeat (cycles) begin
            if (comValid != '0) begin
                $display("%0s: an op committed while no commit was expected", testName);
                otherErrors++;
            end
            @(negedge clk);
        end
    endtask

    task automatic writeReg(logic [`AXI_ADDR_BITS-1:0] addr, logic [`AXI_DATA_BITS-1:0] data,
                            AxiResp expResp);
        int n;
        awaddr  = addr;
        wdata   = data;
        wstrb   = '1;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        while (!awready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!awready) begin
            reportTimeout("awready");
            return;
        end
        if (wready !== 1'b1) begin
            $display("%0s: wready did not rise together with awready", testName);
            otherErrors++;
        end
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        while (!bvalid && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!bvalid) begin
            reportTimeout("bvalid");
            return;
        end
        checkReg('0, expResp, '0, AxiResp'(bresp));
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
        if (addr == regCommits) begin
            modelCommits = 0;
        end
        if (addr == regFlushes) begin
            modelFlushes = 0;
        end
    endtask

    task automatic readReg(logic [`AXI_ADDR_BITS-1:0] addr,
                           output logic [`AXI_DATA_BITS-1:0] data, output AxiResp resp);
        int n;
        data    = 'x;
        resp    = respSlvErr;
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        while (!arready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!arready) begin
            reportTimeout("arready");
            return;
        end
        @(negedge clk);
        arvalid = 1'b0;
        n = 0;
        while (!rvalid && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!rvalid) begin
            reportTimeout("rvalid");
            return;
        end
        data   = rdata;
        resp   = AxiResp'(rresp);
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic readExpect(logic [`AXI_ADDR_BITS-1:0] addr,
                              logic [`AXI_DATA_BITS-1:0] expData, AxiResp expResp);
        logic [`AXI_DATA_BITS-1:0] data;
        AxiResp                    resp;
        readReg(addr, data, resp);
        if (!hung) begin
            checkReg(expData, expResp, data, resp);
        end
    endtask

    task automatic checkCounters();
        readExpect(regCommits, modelCommits, respOkay);
        readExpect(regFlushes, modelFlushes, respOkay);
    endtask

    initial begin
        integer          fd;
        integer          got;
        integer          want;
        integer          ch;
        logic [8*16-1:0] cmd;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     c;
        logic [31:0]     d;
        logic [31:0]     e;
        rst       = 1'b1;
        dispValid = '0;
        dispDst   = '0;
        wbValid   = '0;
        wbSqN     = '0;
        for (int p = 0; p < `ROB_WB_PORTS; p++) begin
            wbFlags[p] = flagsNone;
        end
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        valueErrors  = 0;
        otherErrors  = 0;
        hung         = 1'b0;
        modelHead    = '0;
        modelTail    = '0;
        modelCommits = 0;
        modelFlushes = 0;
        comTime      = '1;
        flushTime    = '1;
        testName     = "reset";
        repeat (8) @(negedge clk);
        rst = 1'b0;

        fd = $fopen("test/rob_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open test/rob_tests.txt");
            otherErrors++;
        end else begin
            while (!hung && $fscanf(fd, "%s", cmd) == 1) begin
                got  = 0;
                want = 0;
                if (cmd == "#") begin
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end else if (cmd == "test") begin
                    want = 1;
                    got  = $fscanf(fd, "%s", testName);
                end else if (cmd == "disp") begin
                    want = 3;
                    got  = $fscanf(fd, "%h %h %h", a, b, c);
                    dispatchOps(a[`ROB_WIDTH-1:0], RegNm'(b), RegNm'(c));
                end else if (cmd == "wb") begin
                    want = 5;
                    got  = $fscanf(fd, "%h %h %h %h %h", a, b, c, d, e);
                    writeBack(a[`ROB_WB_PORTS-1:0], SqN'(b), CompFlags'(c[1:0]),
                        SqN'(d), CompFlags'(e[1:0]));
                end else if (cmd == "axw") begin
                    want = 3;
                    got  = $fscanf(fd, "%h %h %h", a, b, c);
                    writeReg(a[`AXI_ADDR_BITS-1:0], b, AxiResp'(c[1:0]));
                end else if (cmd == "axr") begin
                    want = 3;
                    got  = $fscanf(fd, "%h %h %h", a, b, c);
                    readExpect(a[`AXI_ADDR_BITS-1:0], b, AxiResp'(c[1:0]));
                end else if (cmd == "commit") begin
                    want = 3;
                    got  = $fscanf(fd, "%h %h %h", a, b, c);
                    expectCommits(int'(a), SqN'(b), int'(c));
                end else if (cmd == "flush") begin
                    want = 2;
                    got  = $fscanf(fd, "%h %h", a, b);
                    expectFlush(SqN'(a), FlushCause'(b[0]));
                end else if (cmd == "quiet") begin
                    want = 1;
                    got  = $fscanf(fd, "%h", a);
                    expectQuiet(int'(a));
                end else if (cmd == "ready") begin
                    want = 1;
                    got  = $fscanf(fd, "%h", a);
                    checkReady(a[0], dispReady);
                end else if (cmd == "counts") begin
                    checkCounters();
                end else begin
                    $display("Unknown command %0s in test/rob_tests.txt", cmd);
                    otherErrors++;
                end
                if (got != want) begin
                    $display("Missing fields after %0s in test/rob_tests.txt", cmd);
                    otherErrors++;
                end
            end
            $fclose(fd);
        end

        $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
